/* tpmSpiPkg.sv */
// shared types for the TPM SPI controller; header layout and field widths are fixed by the TPM SPI protocol
package tpmSpiPkg;

	typedef logic [7:0] spiByte_t;	// one serializer or FRS byte
	typedef logic [15:0] frsAddr_t;	// FRS byte address
	typedef logic [5:0] xferSize_t;	// size field, bytes minus one

	localparam spiByte_t WAIT_BYTE = 8'hFF;	// wait byte and idle value
	localparam int HEADER_BYTES = 4;	// header length in bytes

	// command header as received, msb first
	typedef struct packed {
		logic readNotWrite;	// 1 = read
		logic reserved;
		xferSize_t size;
		logic [7:0] addrHigh;	// not decoded
		frsAddr_t addr;
	} cmdHeader_t;

	// FRS side of one transfer path
	typedef struct packed {
		frsAddr_t addr;
		logic wrenN;	// active low
		logic rdenN;	// active low
		spiByte_t wrByte;
	} frsBus_t;

	// serializer side of one transfer path
	typedef struct packed {
		spiByte_t txByte;
		logic txValid;	// one cycle pulse
	} spiTx_t;

	// top level sequencer phase
	typedef enum logic [1:0] {
		Idle,
		ObtainHeader,
		Stall,
		Transaction
	} seqState_t;

	typedef enum logic [2:0] {
		HdrIdle,
		HdrWaitRx,	// wait for rx valid
		HdrHold,	// wait for rx valid to drop
		HdrShift,
		HdrComplete
	} headerState_t;

	typedef enum logic [3:0] {
		RdIdle,
		RdTxWait,
		RdTxSend,
		RdTxHold,
		RdSetup,
		RdRead0,
		RdRead1,
		RdUpdateAddr,
		RdComplete
	} readState_t;

	typedef enum logic [3:0] {
		WrIdle,
		WrTxWait,
		WrTxSend,
		WrTxHold,
		WrSetup,
		WrRxWait,
		WrWrite0,
		WrWrite1,
		WrUpdateAddr,
		WrComplete
	} writeState_t;

endpackage

/* tpmHeaderCollect.sv */
// collects the command header msb first; a held rx valid counts as one byte
`timescale 1ns/1ps

module tpmHeaderCollect import tpmSpiPkg::*; (
	input logic clock_i,
	input logic reset_n_i,
	input seqState_t phase_i,	// sequencer phase
	input spiByte_t rxByte_i,
	input logic rxValid_i,
	output cmdHeader_t header_o,
	output logic headerDone_o
);

	localparam logic [HEADER_BYTES-1:0] TRACK_INIT = {1'b1, {(HEADER_BYTES-1){1'b0}}};

	headerState_t state, next;
	logic [$bits(cmdHeader_t)-1:0] headerReg;	// assembly shift register
	logic [HEADER_BYTES-1:0] byteTracker;	// one-hot, walks toward bit 0

	always_ff @(posedge clock_i or negedge reset_n_i)
	begin
		if (!reset_n_i)
			state <= HdrIdle;
		else
			state <= next;
	end

	always_comb
	begin
		next = state;
		if (phase_i == Idle)
			next = HdrIdle;
		else
		begin
			case (state)
				HdrIdle: if (phase_i == ObtainHeader) next = HdrWaitRx;
				HdrWaitRx: if (rxValid_i) next = HdrHold;
				HdrHold:
				begin
					// leave only once valid has dropped
					if (!rxValid_i)
						next = byteTracker[0] ? HdrComplete : HdrShift;
				end
				HdrShift: next = HdrWaitRx;
				HdrComplete: next = HdrComplete;	// until phase goes Idle
				default: next = HdrIdle;
			endcase
		end
	end

	always_ff @(posedge clock_i or negedge reset_n_i)
	begin
		if (!reset_n_i)
		begin
			headerReg <= '0;
			byteTracker <= TRACK_INIT;
		end
		else
		begin
			case (state)
				HdrIdle:
				begin
					headerReg <= '0;	// cleared between transactions
					byteTracker <= TRACK_INIT;
				end
				HdrWaitRx: if (rxValid_i) headerReg[7:0] <= rxByte_i;	// newest byte in low end
				HdrShift:
				begin
					headerReg <= headerReg << 8;
					byteTracker <= byteTracker >> 1;
				end
				default: ;
			endcase
		end
	end

	assign header_o = cmdHeader_t'(headerReg);
	assign headerDone_o = (state == HdrComplete);

endmodule

/* tpmReadXfer.sv */
// read path FRS to serializer; FRS read data must be valid within the two read cycles
`timescale 1ns/1ps

module tpmReadXfer import tpmSpiPkg::*; (
	input logic clock_i,
	input logic reset_n_i,
	input seqState_t phase_i,	// sequencer phase
	input cmdHeader_t header_i,
	input frsAddr_t baseAddr_i,	// latched in Stall
	input spiByte_t frsRdByte_i,
	output frsBus_t frs_o,
	output spiTx_t spiTx_o,
	input logic txPrepare_i,
	input logic txAck_i
);

	readState_t state, next;
	frsAddr_t rdAddr;
	xferSize_t bytesSent;	// starts all ones, wraps to 0 on first byte
	spiByte_t txByte;
	logic waitPhase;	// wait byte still outstanding

	always_ff @(posedge clock_i or negedge reset_n_i)
	begin
		if (!reset_n_i)
			state <= RdIdle;
		else
			state <= next;
	end

	always_comb
	begin
		next = state;
		if (phase_i == Idle)
			next = RdIdle;
		else
		begin
			case (state)
				RdIdle:
				begin
					if (phase_i == Transaction && header_i.readNotWrite)
						next = RdTxWait;
				end
				RdTxWait: if (txPrepare_i) next = RdTxSend;
				RdTxSend: next = RdTxHold;
				RdTxHold:
				begin
					// first ack is the wait byte
					if (txAck_i)
						next = waitPhase ? RdSetup : RdUpdateAddr;
				end
				RdSetup: next = RdRead0;
				RdRead0: next = RdRead1;
				RdRead1: next = RdTxWait;
				RdUpdateAddr: next = (bytesSent == header_i.size) ? RdComplete : RdRead0;
				RdComplete: next = RdComplete;	// until phase goes Idle
				default: next = RdIdle;
			endcase
		end
	end

	always_ff @(posedge clock_i or negedge reset_n_i)
	begin
		if (!reset_n_i)
		begin
			rdAddr <= 16'h0001;
			bytesSent <= '1;
			txByte <= WAIT_BYTE;
			waitPhase <= 1'b1;
		end
		else
		begin
			case (state)
				RdIdle:
				begin
					rdAddr <= 16'h0001;
					bytesSent <= '1;
					txByte <= WAIT_BYTE;	// first offer is the wait byte
					waitPhase <= 1'b1;
				end
				RdSetup:
				begin
					rdAddr <= baseAddr_i;
					bytesSent <= '1;
					waitPhase <= 1'b0;
				end
				RdRead1: txByte <= frsRdByte_i;	// end of two cycle read
				RdTxSend:
				begin
					rdAddr <= rdAddr + 16'd1;	// next byte address
					bytesSent <= bytesSent + 6'd1;
				end
				default: ;
			endcase
		end
	end

	// output bundles
	always_comb
	begin
		frs_o.addr = rdAddr;
		frs_o.wrenN = 1'b1;	// never writes
		frs_o.rdenN = !(state == RdRead0 || state == RdRead1);
		frs_o.wrByte = WAIT_BYTE;
		spiTx_o.txByte = txByte;
		spiTx_o.txValid = (state == RdTxSend);	// one cycle offer
	end

endmodule

/* tpmWriteXfer.sv */
// write path serializer to FRS; rx valid is expected as a single cycle pulse per byte
`timescale 1ns/1ps

module tpmWriteXfer import tpmSpiPkg::*; (
	input logic clock_i,
	input logic reset_n_i,
	input seqState_t phase_i,	// sequencer phase
	input cmdHeader_t header_i,
	input frsAddr_t baseAddr_i,	// latched in Stall
	input spiByte_t rxByte_i,
	input logic rxValid_i,
	output frsBus_t frs_o,
	output spiTx_t spiTx_o,
	input logic txPrepare_i,
	input logic txAck_i
);

	writeState_t state, next;
	frsAddr_t wrAddr;
	xferSize_t bytesWritten;	// starts all ones, wraps to 0 on first byte
	spiByte_t wrByte;	// held stable through the strobe

	always_ff @(posedge clock_i or negedge reset_n_i)
	begin
		if (!reset_n_i)
			state <= WrIdle;
		else
			state <= next;
	end

	always_comb
	begin
		next = state;
		if (phase_i == Idle)
			next = WrIdle;
		else
		begin
			case (state)
				WrIdle:
				begin
					if (phase_i == Transaction && !header_i.readNotWrite)
						next = WrTxWait;
				end
				WrTxWait: if (txPrepare_i) next = WrTxSend;
				WrTxSend: next = WrTxHold;
				WrTxHold: if (txAck_i) next = WrSetup;	// wait byte taken
				WrSetup: next = WrRxWait;
				WrRxWait: if (rxValid_i) next = WrWrite0;
				WrWrite0: next = WrWrite1;
				WrWrite1:
				begin
					// last byte when count reaches the size field
					next = (bytesWritten == header_i.size) ? WrComplete : WrUpdateAddr;
				end
				WrUpdateAddr: next = WrRxWait;
				WrComplete: next = WrComplete;	// until phase goes Idle
				default: next = WrIdle;
			endcase
		end
	end

	always_ff @(posedge clock_i or negedge reset_n_i)
	begin
		if (!reset_n_i)
		begin
			wrAddr <= 16'h0001;
			bytesWritten <= '1;
			wrByte <= WAIT_BYTE;
		end
		else
		begin
			case (state)
				WrIdle:
				begin
					wrAddr <= 16'h0001;
					bytesWritten <= '1;
					wrByte <= WAIT_BYTE;
				end
				WrSetup:
				begin
					wrAddr <= baseAddr_i;
					bytesWritten <= '1;
				end
				WrRxWait:
				begin
					// take the byte on the valid cycle
					if (rxValid_i)
					begin
						wrByte <= rxByte_i;
						bytesWritten <= bytesWritten + 6'd1;
					end
				end
				WrUpdateAddr: wrAddr <= wrAddr + 16'd1;
				default: ;
			endcase
		end
	end

	// output bundles
	always_comb
	begin
		frs_o.addr = wrAddr;
		frs_o.wrenN = !(state == WrWrite0 || state == WrWrite1);	// two cycle strobe
		frs_o.rdenN = 1'b1;	// never reads
		frs_o.wrByte = wrByte;
		spiTx_o.txByte = WAIT_BYTE;	// only the wait byte goes out
		spiTx_o.txValid = (state == WrTxSend);
	end

endmodule

/* tpmSpiCtrl.sv */
// TPM SPI transaction controller; one wait byte per transaction, no timeout on a stalled serializer
`timescale 1ns/1ps

module tpmSpiCtrl import tpmSpiPkg::*; (
	input logic clock_i,
	input logic reset_n_i,

	input logic spiCsN_i,	// chip select, active low
	input spiByte_t spiRxByte_i,
	input logic spiRxValid_i,	// rx byte strobe

	output spiByte_t spiTxByte_o,
	output logic spiTxValid_o,	// tx byte offer pulse
	input logic spiTxPrepare_i,	// serializer ready for a byte
	input logic spiTxAck_i,	// serializer took the byte

	output frsAddr_t frsAddr_o,
	output logic frsWrenN_o,
	output logic frsRdenN_o,
	output spiByte_t frsWrByte_o,
	input spiByte_t frsRdByte_i,	// combinational from frsAddr_o

	output frsAddr_t frsBaseAddr_o,	// latched in Stall
	output xferSize_t cmdSize_o,	// latched in Stall
	output logic frsReq_o
);

	seqState_t seqState, seqNext;
	cmdHeader_t header;
	logic headerDone;
	frsBus_t rdFrs, wrFrs, selFrs;
	spiTx_t rdTx, wrTx, selTx;

	// phase register
	always_ff @(posedge clock_i or negedge reset_n_i)
	begin
		if (!reset_n_i)
			seqState <= Idle;
		else
			seqState <= seqNext;
	end

	always_comb
	begin
		seqNext = seqState;
		if (spiCsN_i)
			seqNext = Idle;	// deselect aborts from anywhere
		else
		begin
			case (seqState)
				Idle: seqNext = ObtainHeader;
				ObtainHeader: if (headerDone) seqNext = Stall;
				Stall: seqNext = Transaction;	// single stall cycle
				Transaction: seqNext = Transaction;	// held until deselect
				default: seqNext = Idle;
			endcase
		end
	end

	// stall step, base address and size for the FRS
	always_ff @(posedge clock_i or negedge reset_n_i)
	begin
		if (!reset_n_i)
		begin
			frsBaseAddr_o <= 16'h0001;
			cmdSize_o <= '0;
		end
		else if (seqState == Stall)
		begin
			frsBaseAddr_o <= header.addr;
			cmdSize_o <= header.size;
		end
	end

	assign frsReq_o = (seqState == Transaction);

	tpmHeaderCollect headerCollect0 (
		.clock_i(clock_i), .reset_n_i(reset_n_i),
		.phase_i(seqState),
		.rxByte_i(spiRxByte_i), .rxValid_i(spiRxValid_i),
		.header_o(header), .headerDone_o(headerDone)
	);

	tpmReadXfer readXfer0 (
		.clock_i(clock_i), .reset_n_i(reset_n_i),
		.phase_i(seqState), .header_i(header), .baseAddr_i(frsBaseAddr_o),
		.frsRdByte_i(frsRdByte_i),
		.frs_o(rdFrs), .spiTx_o(rdTx),
		.txPrepare_i(spiTxPrepare_i), .txAck_i(spiTxAck_i)
	);

	tpmWriteXfer writeXfer0 (
		.clock_i(clock_i), .reset_n_i(reset_n_i),
		.phase_i(seqState), .header_i(header), .baseAddr_i(frsBaseAddr_o),
		.rxByte_i(spiRxByte_i), .rxValid_i(spiRxValid_i),
		.frs_o(wrFrs), .spiTx_o(wrTx),
		.txPrepare_i(spiTxPrepare_i), .txAck_i(spiTxAck_i)
	);

	// path select by direction bit
	assign selFrs = header.readNotWrite ? rdFrs : wrFrs;
	assign selTx = header.readNotWrite ? rdTx : wrTx;

	assign frsAddr_o = selFrs.addr;
	assign frsWrByte_o = selFrs.wrByte;
	assign frsWrenN_o = (seqState == Idle) ? 1'b1 : selFrs.wrenN;	// strobes quiet in Idle
	assign frsRdenN_o = (seqState == Idle) ? 1'b1 : selFrs.rdenN;

	assign spiTxValid_o = selTx.txValid;
	assign spiTxByte_o = (seqState == Transaction) ? selTx.txByte : 8'h00;

endmodule

/* tbTasks.svh */
// serializer model, LFSR and directed tests; uses the signals of tb_tpmSpiCtrl, drives on falling edges
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

	localparam int WAIT_LIMIT = 200;	// cycles allowed for any single wait

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one LFSR step per bit taken
	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsrState = lfsrStep(lfsrState);
			bits = {bits[30:0], lfsrState[0]};
		end
		return bits;
	endfunction

	task automatic compareValue(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		checkCount++;
		assert (actual === expected)
		else
		begin
			errorCount++;
			$display("Error at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
		end
	endtask

	// one cycle rx pulse and a gap until the receiving FSM waits again
	task automatic sendByte(input spiByte_t value);
		@(negedge clock);
		spiRxByte = value;
		spiRxValid = 1'b1;
		@(negedge clock);
		spiRxValid = 1'b0;
		repeat (3) @(negedge clock);
	endtask

	task automatic takeTxByte(output spiByte_t value);
		int waited;
		waited = 0;
		@(negedge clock);
		spiTxPrepare = 1'b1;	// kept up until the offer shows
		@(negedge clock);
		while (!spiTxValid && waited < WAIT_LIMIT)
		begin
			@(negedge clock);
			waited++;
		end
		spiTxPrepare = 1'b0;
		if (!spiTxValid)
		begin
			value = 8'h00;
			$display("no tx byte was offered within %0d cycles", WAIT_LIMIT);
			errorCount++;
		end
		else
		begin
			value = spiTxByte;
			@(negedge clock);
			spiTxAck = 1'b1;	// lands while the FSM holds the offer
			@(negedge clock);
			spiTxAck = 1'b0;
		end
	endtask

	// selects the DUT and sends the first byteCount header bytes msb first
	task automatic sendHeader(input logic readNotWrite, input xferSize_t size,
		input frsAddr_t addr, input int byteCount);
		cmdHeader_t header;
		logic [31:0] bits;
		header.readNotWrite = readNotWrite;
		header.reserved = 1'b0;
		header.size = size;
		header.addrHigh = 8'(randomBits(8));	// ignored by the DUT
		header.addr = addr;
		bits = header;
		@(negedge clock);
		spiCsN = 1'b0;
		repeat (2) @(negedge clock);	// sequencer and collector leave idle
		for (int i = 0; i < byteCount; i++)
			sendByte(8'(bits >> (8 * (HEADER_BYTES - 1 - i))));
	endtask

	task automatic waitForRequest();
		int waited;
		waited = 0;
		while (!frsReq && waited < WAIT_LIMIT)
		begin
			@(negedge clock);
			waited++;
		end
		if (!frsReq)
		begin
			$display("frsReq_o did not rise after the header");
			errorCount++;
		end
	endtask

	task automatic deselect();
		@(negedge clock);
		spiCsN = 1'b1;
		repeat (3) @(negedge clock);	// all FSMs back in idle
	endtask

	task automatic resetValues();
		compareValue(32'(spiTxValid), 32'd0, "spiTxValid_o after reset");
		compareValue(32'(frsWrenN), 32'd1, "frsWrenN_o after reset");
		compareValue(32'(frsRdenN), 32'd1, "frsRdenN_o after reset");
		compareValue(32'(frsReq), 32'd0, "frsReq_o after reset");
		compareValue(32'(frsBaseAddr), 32'h0001, "frsBaseAddr_o after reset");
		compareValue(32'(spiTxByte), 32'd0, "spiTxByte_o outside a transaction");
	endtask

	// full read checked against the FRS model
	task automatic readAndCheck(input frsAddr_t base, input xferSize_t size);
		spiByte_t got;
		frsAddr_t addr;
		int rdStart;
		rdStart = rdStrobeCycles;
		sendHeader(1'b1, size, base, HEADER_BYTES);
		waitForRequest();
		compareValue(32'(frsBaseAddr), 32'(base), "frsBaseAddr_o");
		compareValue(32'(cmdSize), 32'(size), "cmdSize_o");
		takeTxByte(got);
		compareValue(32'(got), 32'h00FF, "read wait byte");
		for (int i = 0; i <= int'(size); i++)
		begin
			addr = base + 16'(i);
			takeTxByte(got);
			compareValue(32'(got), 32'(frsMem[addr]), $sformatf("read byte %0d", i));
		end
		deselect();
		compareValue(32'(frsReq), 32'd0, "frsReq_o after deselect");
		// two read strobe cycles per byte
		compareValue(32'(rdStrobeCycles - rdStart), 32'(2 * (int'(size) + 1)),
			"read strobe cycles");
	endtask

	task automatic readOneByte();
		readAndCheck(16'h00D4, 6'd0);
	endtask

	task automatic readEightBytes();
		readAndCheck(16'(randomBits(16)), 6'd7);
	endtask

	task automatic writeFourBytes();
		frsAddr_t base, addr;
		spiByte_t data [$];
		spiByte_t got;
		int logStart, rdStart, waited;
		base = 16'(randomBits(16));
		for (int i = 0; i < 4; i++)
			data.push_back(8'(randomBits(8)));
		logStart = wrLog.size();
		rdStart = rdStrobeCycles;
		sendHeader(1'b0, 6'd3, base, HEADER_BYTES);
		waitForRequest();
		takeTxByte(got);
		compareValue(32'(got), 32'h00FF, "write wait byte");
		for (int i = 0; i < 4; i++)
			sendByte(data[i]);
		waited = 0;
		while (wrLog.size() - logStart < 8 && waited < WAIT_LIMIT)
		begin
			@(negedge clock);
			waited++;
		end
		compareValue(32'(wrLog.size() - logStart), 32'd8, "write strobe cycles");
		for (int i = 0; i < 8 && logStart + i < wrLog.size(); i++)
		begin
			addr = base + 16'(i / 2);	// two strobe cycles per address
			compareValue(32'(wrLog[logStart + i].addr), 32'(addr),
				$sformatf("write address, strobe cycle %0d", i));
			compareValue(32'(wrLog[logStart + i].data), 32'(data[i / 2]),
				$sformatf("write byte, strobe cycle %0d", i));
		end
		compareValue(32'(rdStrobeCycles - rdStart), 32'd0, "read strobes during write");
		deselect();
	endtask

	// deselect mid header and follow with a clean read
	task automatic abortAndRead();
		frsAddr_t base;
		int logStart, rdStart, reqStart;
		base = 16'(randomBits(16));
		logStart = wrLog.size();
		rdStart = rdStrobeCycles;
		reqStart = reqCycles;
		sendHeader(1'b1, 6'd2, base, 2);
		deselect();
		compareValue(32'(reqCycles - reqStart), 32'd0, "frsReq_o cycles after abort");
		compareValue(32'(rdStrobeCycles - rdStart), 32'd0, "read strobes after abort");
		compareValue(32'(wrLog.size() - logStart), 32'd0, "write strobes after abort");
		readAndCheck(base, 6'd3);
	endtask

`endif

/* tb_tpmSpiCtrl.sv */
// testbench for tpmSpiCtrl; FRS and serializer are behavioral models, inputs change on falling edges
`timescale 1ns/1ps

module tb_tpmSpiCtrl import tpmSpiPkg::*; ();

	typedef struct packed {
		frsAddr_t addr;
		spiByte_t data;
	} wrRecord_t;	// one write strobe cycle

	logic clock, resetN;
	logic spiCsN, spiRxValid, spiTxValid, spiTxPrepare, spiTxAck;
	spiByte_t spiRxByte, spiTxByte, frsWrByte, frsRdByte;
	frsAddr_t frsAddr, frsBaseAddr;
	logic frsWrenN, frsRdenN, frsReq;
	xferSize_t cmdSize;

	spiByte_t frsMem [0:65535];	// 64 KiB FRS model
	wrRecord_t wrLog [$];	// one entry per strobe cycle
	logic [31:0] lfsrState = 32'h9d12ed82;
	int errorCount = 0;
	int checkCount = 0;
	int reqCycles = 0;	// cycles with frsReq_o high
	int rdStrobeCycles = 0;	// cycles with frsRdenN_o low

	// closing summary and verdict
	task automatic finishRun();
		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	endtask

	`include "tbTasks.svh"

	tpmSpiCtrl dut0 (
		.clock_i(clock), .reset_n_i(resetN),
		.spiCsN_i(spiCsN), .spiRxByte_i(spiRxByte), .spiRxValid_i(spiRxValid),
		.spiTxByte_o(spiTxByte), .spiTxValid_o(spiTxValid),
		.spiTxPrepare_i(spiTxPrepare), .spiTxAck_i(spiTxAck),
		.frsAddr_o(frsAddr), .frsWrenN_o(frsWrenN), .frsRdenN_o(frsRdenN),
		.frsWrByte_o(frsWrByte), .frsRdByte_i(frsRdByte),
		.frsBaseAddr_o(frsBaseAddr), .cmdSize_o(cmdSize), .frsReq_o(frsReq)
	);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;	// 10 ns period
	end

	assign frsRdByte = frsMem[frsAddr];	// combinational FRS read

	// LFSR byte mixed with both address bytes
	task automatic fillMemory();
		for (int a = 0; a < 65536; a++)
			frsMem[16'(a)] = 8'(randomBits(8)) ^ 8'(a) ^ 8'(a >> 8);
	endtask

	// write and strobe monitor on the falling edge
	always @(negedge clock)
	begin
		if (!frsWrenN)
			wrLog.push_back(wrRecord_t'({frsAddr, frsWrByte}));
		if (!frsRdenN)
			rdStrobeCycles++;
		if (frsReq)
			reqCycles++;
	end

	initial
	begin
		spiCsN = 1'b1;	// deselected
		spiRxByte = 8'h00;
		spiRxValid = 1'b0;
		spiTxPrepare = 1'b0;
		spiTxAck = 1'b0;
		resetN = 1'b0;
		fillMemory();
		repeat (5) @(posedge clock);	// reset held 5 cycles
		@(negedge clock);
		resetN = 1'b1;
		resetValues();
		readOneByte();
		readEightBytes();
		writeFourBytes();
		abortAndRead();
		finishRun();
	end

endmodule

/* sim.f */
+incdir+.
tpmSpiPkg.sv
tpmHeaderCollect.sv
tpmReadXfer.sv
tpmWriteXfer.sv
tpmSpiCtrl.sv
tb_tpmSpiCtrl.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_tpmSpiCtrl -f sim.f -o simv
	@out="$$(./obj_dir/simv)"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
